// File: common/riscv_isa_pkg.sv
package riscv_isa_pkg;

  // major opcodes are kept at full width so every value ends in 2'b11
  typedef enum logic [6:0] {
    LOAD     = 7'b0000011,
    MISC_MEM = 7'b0001111,
    OP_IMM   = 7'b0010011,
    AUIPC    = 7'b0010111,
    STORE    = 7'b0100011,
    OP       = 7'b0110011,
    LUI      = 7'b0110111,
    BRANCH   = 7'b1100011,
    JALR     = 7'b1100111,
    JAL      = 7'b1101111,
    SYSTEM   = 7'b1110011
  } opcode_e;

  // funct7 of SUB and SRA/SRAI
  localparam logic [6:0] FUNCT7_ALT  = 7'b0100000;
  localparam logic [6:0] FUNCT7_BASE = 7'b0000000;

  // load and store sizes follow funct3 directly
  typedef enum logic [2:0] {
    LDST_B  = 3'b000,
    LDST_H  = 3'b001,
    LDST_W  = 3'b010,
    LDST_BU = 3'b100,
    LDST_HU = 3'b101
  } ldst_size_e;

  // funct12 field of mret in the SYSTEM opcode
  localparam logic [11:0] MRET_FIELD = 12'b0011000_00010;

  // machine mode CSR addresses
  localparam logic [11:0] CSR_MTVEC  = 12'h305;
  localparam logic [11:0] CSR_MEPC   = 12'h341;
  localparam logic [11:0] CSR_MCAUSE = 12'h342;

  // the interrupt bit is set and the code is the machine external interrupt
  localparam logic [31:0] INT_CAUSE = 32'h8000_000B;

endpackage

// File: common/riscv_ctrl_pkg.sv
package riscv_ctrl_pkg;

  typedef enum logic [1:0] {
    OP_A_RS1,
    OP_A_CURR_PC,
    OP_A_ZERO
  } op_a_sel_e;

  typedef enum logic [2:0] {
    OP_B_RS2,
    OP_B_IMM_I,
    OP_B_IMM_U,
    OP_B_IMM_S,
    OP_B_INCR
  } op_b_sel_e;

  // upper two bits of an ALU operation select the group
  localparam logic [1:0] ALU_GRP_BASE = 2'b00;
  localparam logic [1:0] ALU_GRP_ALT  = 2'b01;
  localparam logic [1:0] ALU_GRP_CMP  = 2'b11;

  // low three bits carry funct3 so the decoder can pass it straight through
  typedef enum logic [4:0] {
    ALU_ADD  = 5'b00_000,
    ALU_SLL  = 5'b00_001,
    ALU_SLT  = 5'b00_010,
    ALU_SLTU = 5'b00_011,
    ALU_XOR  = 5'b00_100,
    ALU_SRL  = 5'b00_101,
    ALU_OR   = 5'b00_110,
    ALU_AND  = 5'b00_111,
    ALU_SUB  = 5'b01_000,
    ALU_SRA  = 5'b01_101,
    ALU_EQ   = 5'b11_000,
    ALU_NE   = 5'b11_001,
    ALU_LT   = 5'b11_100,
    ALU_GE   = 5'b11_101,
    ALU_LTU  = 5'b11_110,
    ALU_GEU  = 5'b11_111
  } alu_op_e;

  typedef enum logic {
    WB_EX_RESULT,
    WB_LSU_DATA
  } wb_src_e;

  typedef enum logic [1:0] {
    JALR_NONE,
    JALR_RS1,
    JALR_MEPC,
    JALR_MTVEC
  } jalr_src_e;

  typedef enum logic [1:0] {
    CSR_NONE,
    CSR_WRITE,
    CSR_CLEAR,
    CSR_SET
  } csr_op_e;

endpackage

// File: source/decoder_riscv.sv
`timescale 1ns/10ps

module decoder_riscv
  import riscv_isa_pkg::*;
  import riscv_ctrl_pkg::*;
(
  input  logic [31:0] fetched_instr_i,
  input  logic        lsu_stall_req_i,
  input  logic        int_i,
  output op_a_sel_e   ex_op_a_sel_o,
  output op_b_sel_e   ex_op_b_sel_o,
  output alu_op_e     alu_op_o,
  output logic        mem_req_o,
  output logic        mem_we_o,
  output logic [2:0]  mem_size_o,
  output logic        gpr_we_a_o,
  output wb_src_e     wb_src_sel_o,
  output logic        illegal_instr_o,
  output logic        branch_o,
  output logic        jal_o,
  output jalr_src_e   jalr_o,
  output logic        enpc_o,
  output logic        int_rst_o,
  output logic        csr_o,
  output logic [2:0]  csr_op_o
);

  opcode_e    opcode;
  logic [2:0] funct3;
  logic [6:0] funct7;
  logic       gpr_we;
  logic       mem_req;
  csr_op_e    csr_op;

  // any word whose low bits are not 11 misses every opcode and lands in default
  assign opcode = opcode_e'(fetched_instr_i[6:0]);
  assign funct3 = fetched_instr_i[14:12];
  assign funct7 = fetched_instr_i[31:25];

  assign enpc_o     = ~lsu_stall_req_i;
  assign gpr_we_a_o = gpr_we & enpc_o;
  assign mem_req_o  = mem_req & ~int_i;
  assign csr_op_o   = {int_i, csr_op};

  // ################################################
  // main decode
  // ################################################

  always_comb begin
    // start from a no-op and let each opcode turn on what it needs
    ex_op_a_sel_o   = OP_A_RS1;
    ex_op_b_sel_o   = OP_B_IMM_I;
    alu_op_o        = ALU_ADD;
    mem_req         = 1'b0;
    mem_we_o        = 1'b0;
    mem_size_o      = LDST_W;
    gpr_we          = 1'b0;
    wb_src_sel_o    = WB_EX_RESULT;
    illegal_instr_o = 1'b0;
    branch_o        = 1'b0;
    jal_o           = 1'b0;
    jalr_o          = JALR_NONE;
    int_rst_o       = 1'b0;
    csr_o           = 1'b0;
    csr_op          = CSR_NONE;

    case (opcode)
      LOAD: begin
        mem_req      = 1'b1;
        mem_size_o   = funct3;
        gpr_we       = 1'b1;
        wb_src_sel_o = WB_LSU_DATA;
        if (!(funct3 inside {LDST_B, LDST_H, LDST_W, LDST_BU, LDST_HU}))
          illegal_instr_o = 1'b1;
      end

      MISC_MEM: begin
        // fence has nothing to order in a single-cycle core
      end

      OP_IMM: begin
        alu_op_o = alu_op_e'({ALU_GRP_BASE, funct3});
        gpr_we   = 1'b1;
        if (funct3 == 3'b001 && funct7 != FUNCT7_BASE)
          illegal_instr_o = 1'b1;
        if (funct3 == 3'b101) begin
          if (funct7 == FUNCT7_ALT)
            alu_op_o = alu_op_e'({ALU_GRP_ALT, funct3});
          else if (funct7 != FUNCT7_BASE)
            illegal_instr_o = 1'b1;
        end
      end

      AUIPC: begin
        ex_op_a_sel_o = OP_A_CURR_PC;
        ex_op_b_sel_o = OP_B_IMM_U;
        gpr_we        = 1'b1;
      end

      STORE: begin
        ex_op_b_sel_o = OP_B_IMM_S;
        mem_req       = 1'b1;
        mem_we_o      = 1'b1;
        mem_size_o    = funct3;
        if (!(funct3 inside {LDST_B, LDST_H, LDST_W}))
          illegal_instr_o = 1'b1;
      end

      OP: begin
        ex_op_b_sel_o = OP_B_RS2;
        alu_op_o      = alu_op_e'({ALU_GRP_BASE, funct3});
        gpr_we        = 1'b1;
        if (funct7 == FUNCT7_ALT) begin
          alu_op_o = alu_op_e'({ALU_GRP_ALT, funct3});
          // only SUB and SRA exist in the alternate group
          if (funct3 != 3'b000 && funct3 != 3'b101)
            illegal_instr_o = 1'b1;
        end else if (funct7 != FUNCT7_BASE) begin
          illegal_instr_o = 1'b1;
        end
      end

      LUI: begin
        ex_op_a_sel_o = OP_A_ZERO;
        ex_op_b_sel_o = OP_B_IMM_U;
        gpr_we        = 1'b1;
      end

      BRANCH: begin
        ex_op_b_sel_o = OP_B_RS2;
        alu_op_o      = alu_op_e'({ALU_GRP_CMP, funct3});
        branch_o      = 1'b1;
        if (funct3 == 3'b010 || funct3 == 3'b011)
          illegal_instr_o = 1'b1;
      end

      JALR: begin
        ex_op_a_sel_o = OP_A_CURR_PC;
        ex_op_b_sel_o = OP_B_INCR;
        gpr_we        = 1'b1;
        jalr_o        = JALR_RS1;
        if (funct3 != 3'b000)
          illegal_instr_o = 1'b1;
      end

      JAL: begin
        ex_op_a_sel_o = OP_A_CURR_PC;
        ex_op_b_sel_o = OP_B_INCR;
        gpr_we        = 1'b1;
        jal_o         = 1'b1;
      end

      SYSTEM: begin
        case (funct3)
          3'b000: begin
            if (fetched_instr_i[31:20] == MRET_FIELD) begin
              jalr_o    = JALR_MEPC;
              int_rst_o = 1'b1;
            end else begin
              illegal_instr_o = 1'b1;
            end
          end
          3'b001: begin
            csr_o  = 1'b1;
            gpr_we = 1'b1;
            csr_op = CSR_WRITE;
          end
          3'b010: begin
            csr_o  = 1'b1;
            gpr_we = 1'b1;
            csr_op = CSR_SET;
          end
          3'b011: begin
            csr_o  = 1'b1;
            gpr_we = 1'b1;
            csr_op = CSR_CLEAR;
          end
          default: illegal_instr_o = 1'b1;
        endcase
      end

      default: illegal_instr_o = 1'b1;
    endcase

    // a rejected word behaves as a plain step to the next instruction
    if (illegal_instr_o) begin
      alu_op_o  = ALU_ADD;
      mem_req   = 1'b0;
      gpr_we    = 1'b0;
      branch_o  = 1'b0;
      jal_o     = 1'b0;
      jalr_o    = JALR_NONE;
      int_rst_o = 1'b0;
      csr_o     = 1'b0;
      csr_op    = CSR_NONE;
    end

    if (int_i)
      jalr_o = JALR_MTVEC;
  end

  a_illegal_quiet: assert final (!illegal_instr_o || (!mem_req_o && !gpr_we_a_o))
    else $error("illegal instruction reached memory or register file");

endmodule

// File: source/alu_riscv.sv
`timescale 1ns/10ps

module alu_riscv
  import riscv_ctrl_pkg::*;
(
  input  alu_op_e     operator_i,
  input  logic [31:0] operand_a_i,
  input  logic [31:0] operand_b_i,
  output logic [31:0] result_o,
  output logic        flag_o
);

  logic [4:0] shamt;

  assign shamt = operand_b_i[4:0];

  always_comb begin
    result_o = '0;
    flag_o   = 1'b0;

    case (operator_i)
      ALU_ADD:  result_o = operand_a_i + operand_b_i;
      ALU_SUB:  result_o = operand_a_i - operand_b_i;
      ALU_SLL:  result_o = operand_a_i << shamt;
      ALU_SLT:  result_o = {31'b0, $signed(operand_a_i) < $signed(operand_b_i)};
      ALU_SLTU: result_o = {31'b0, operand_a_i < operand_b_i};
      ALU_XOR:  result_o = operand_a_i ^ operand_b_i;
      ALU_SRL:  result_o = operand_a_i >> shamt;
      ALU_SRA:  result_o = $signed(operand_a_i) >>> shamt;
      ALU_OR:   result_o = operand_a_i | operand_b_i;
      ALU_AND:  result_o = operand_a_i & operand_b_i;

      // branch compares leave the result at zero
      ALU_EQ:   flag_o = (operand_a_i == operand_b_i);
      ALU_NE:   flag_o = (operand_a_i != operand_b_i);
      ALU_LT:   flag_o = ($signed(operand_a_i) < $signed(operand_b_i));
      ALU_GE:   flag_o = ($signed(operand_a_i) >= $signed(operand_b_i));
      ALU_LTU:  flag_o = (operand_a_i < operand_b_i);
      ALU_GEU:  flag_o = (operand_a_i >= operand_b_i);
      default: begin
        result_o = '0;
        flag_o   = 1'b0;
      end
    endcase
  end

  a_flag_cmp_only: assert final (operator_i[4:3] == ALU_GRP_CMP || !flag_o)
    else $error("branch flag raised by a non-compare operation");

endmodule

// File: source/rf_riscv.sv
`timescale 1ns/10ps

module rf_riscv (
  input  logic        clk_i,
  input  logic        rst_n_i,
  input  logic [4:0]  read_addr1_i,
  input  logic [4:0]  read_addr2_i,
  input  logic [4:0]  write_addr_i,
  input  logic [31:0] write_data_i,
  input  logic        write_enable_i,
  output logic [31:0] read_data1_o,
  output logic [31:0] read_data2_o
);

  logic [31:0] regs_q [32];

  // entry zero is cleared by reset and never written, so x0 reads as zero
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      for (int i = 0; i < 32; i++)
        regs_q[i] <= '0;
    end else if (write_enable_i && write_addr_i != 5'd0) begin
      regs_q[write_addr_i] <= write_data_i;
    end
  end

  assign read_data1_o = regs_q[read_addr1_i];
  assign read_data2_o = regs_q[read_addr2_i];

endmodule

// File: source/csr_riscv.sv
`timescale 1ns/10ps

module csr_riscv
  import riscv_isa_pkg::*;
  import riscv_ctrl_pkg::*;
(
  input  logic        clk_i,
  input  logic        rst_n_i,
  input  logic        int_i,
  input  logic [2:0]  op_i,
  input  logic        csr_i,
  input  logic        mret_i,
  input  logic [11:0] addr_i,
  input  logic [31:0] pc_i,
  input  logic [31:0] wdata_i,
  input  logic        enable_i,
  output logic [31:0] rdata_o,
  output logic [31:0] mtvec_o,
  output logic [31:0] mepc_o,
  output logic        int_take_o
);

  logic [31:0] mtvec_q;
  logic [31:0] mepc_q;
  logic [31:0] mcause_q;
  logic        in_service_q;
  logic [31:0] csr_new;
  csr_op_e     op;

  // op_i[2] is the take flag as the decoder saw it, the low bits the CSR operation
  assign op         = csr_op_e'(op_i[1:0]);
  assign int_take_o = int_i & ~in_service_q;
  assign mtvec_o    = mtvec_q;
  assign mepc_o     = mepc_q;

  always_comb begin
    case (addr_i)
      CSR_MTVEC:  rdata_o = mtvec_q;
      CSR_MEPC:   rdata_o = mepc_q;
      CSR_MCAUSE: rdata_o = mcause_q;
      default:    rdata_o = '0;
    endcase
  end

  always_comb begin
    case (op)
      CSR_WRITE: csr_new = wdata_i;
      CSR_SET:   csr_new = rdata_o | wdata_i;
      CSR_CLEAR: csr_new = rdata_o & ~wdata_i;
      default:   csr_new = rdata_o;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      mtvec_q      <= '0;
      mepc_q       <= '0;
      mcause_q     <= '0;
      in_service_q <= 1'b0;
    end else if (enable_i) begin
      if (csr_i) begin
        case (addr_i)
          CSR_MTVEC:  mtvec_q  <= csr_new;
          CSR_MEPC:   mepc_q   <= csr_new;
          CSR_MCAUSE: mcause_q <= csr_new;
          default: ;
        endcase
      end
      // a take overrides a CSR write to mepc or mcause in the same cycle
      if (op_i[2]) begin
        mepc_q       <= pc_i;
        mcause_q     <= INT_CAUSE;
        in_service_q <= 1'b1;
      end else if (mret_i) begin
        in_service_q <= 1'b0;
      end
    end
  end

  a_no_nested_take: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    in_service_q |-> !op_i[2])
    else $error("interrupt taken while a previous one is still in service");

endmodule

// File: source/core_riscv.sv
`timescale 1ns/10ps

module core_riscv
  import riscv_ctrl_pkg::*;
(
  input  logic        clk_i,
  input  logic        rst_n_i,
  input  logic [31:0] instr_i,
  input  logic [31:0] data_rdata_i,
  input  logic        data_stall_i,
  input  logic        int_i,
  output logic [31:0] instr_addr_o,
  output logic        data_req_o,
  output logic        data_we_o,
  output logic [2:0]  data_size_o,
  output logic [31:0] data_addr_o,
  output logic [31:0] data_wdata_o,
  output logic        illegal_instr_o
);

  logic [31:0] pc_q;
  logic [31:0] pc_next;
  logic [31:0] jalr_sum;
  logic [31:0] imm_i;
  logic [31:0] imm_s;
  logic [31:0] imm_b;
  logic [31:0] imm_j;
  logic [31:0] imm_u;
  logic [31:0] rs1_data;
  logic [31:0] rs2_data;
  logic [31:0] op_a;
  logic [31:0] op_b;
  logic [31:0] alu_result;
  logic        alu_flag;
  logic [31:0] wb_data;
  logic [31:0] csr_rdata;
  logic [31:0] mtvec;
  logic [31:0] mepc;
  logic        int_take;
  op_a_sel_e   op_a_sel;
  op_b_sel_e   op_b_sel;
  alu_op_e     alu_op;
  wb_src_e     wb_src;
  jalr_src_e   jalr_src;
  logic        gpr_we;
  logic        branch;
  logic        jal;
  logic        enpc;
  logic        int_rst;
  logic        csr;
  logic [2:0]  csr_op;

  // ################################################
  // immediates and operands
  // ################################################

  assign imm_i = {{20{instr_i[31]}}, instr_i[31:20]};
  assign imm_s = {{20{instr_i[31]}}, instr_i[31:25], instr_i[11:7]};
  assign imm_b = {{20{instr_i[31]}}, instr_i[7], instr_i[30:25], instr_i[11:8], 1'b0};
  assign imm_j = {{12{instr_i[31]}}, instr_i[19:12], instr_i[20], instr_i[30:21], 1'b0};
  assign imm_u = {instr_i[31:12], 12'b0};

  always_comb begin
    case (op_a_sel)
      OP_A_CURR_PC: op_a = pc_q;
      OP_A_ZERO:    op_a = '0;
      default:      op_a = rs1_data;
    endcase
  end

  // jal and jalr link through the ALU as pc + 4
  always_comb begin
    case (op_b_sel)
      OP_B_IMM_I: op_b = imm_i;
      OP_B_IMM_U: op_b = imm_u;
      OP_B_IMM_S: op_b = imm_s;
      OP_B_INCR:  op_b = 32'd4;
      default:    op_b = rs2_data;
    endcase
  end

  assign wb_data = csr ? csr_rdata : (wb_src == WB_LSU_DATA) ? data_rdata_i : alu_result;

  // ################################################
  // program counter
  // ################################################

  assign jalr_sum = rs1_data + imm_i;

  always_comb begin
    case (jalr_src)
      JALR_RS1:   pc_next = {jalr_sum[31:1], 1'b0};
      JALR_MEPC:  pc_next = mepc;
      JALR_MTVEC: pc_next = mtvec;
      default: begin
        if (jal)
          pc_next = pc_q + imm_j;
        else if (branch && alu_flag)
          pc_next = pc_q + imm_b;
        else
          pc_next = pc_q + 32'd4;
      end
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i)
      pc_q <= '0;
    else if (enpc)
      pc_q <= pc_next;
  end

  assign instr_addr_o = pc_q;
  assign data_addr_o  = alu_result;
  assign data_wdata_o = rs2_data;

  decoder_riscv u_decoder (
    .fetched_instr_i (instr_i),
    .lsu_stall_req_i (data_stall_i),
    .int_i           (int_take),
    .ex_op_a_sel_o   (op_a_sel),
    .ex_op_b_sel_o   (op_b_sel),
    .alu_op_o        (alu_op),
    .mem_req_o       (data_req_o),
    .mem_we_o        (data_we_o),
    .mem_size_o      (data_size_o),
    .gpr_we_a_o      (gpr_we),
    .wb_src_sel_o    (wb_src),
    .illegal_instr_o (illegal_instr_o),
    .branch_o        (branch),
    .jal_o           (jal),
    .jalr_o          (jalr_src),
    .enpc_o          (enpc),
    .int_rst_o       (int_rst),
    .csr_o           (csr),
    .csr_op_o        (csr_op)
  );

  alu_riscv u_alu (
    .operator_i  (alu_op),
    .operand_a_i (op_a),
    .operand_b_i (op_b),
    .result_o    (alu_result),
    .flag_o      (alu_flag)
  );

  rf_riscv u_rf (
    .clk_i          (clk_i),
    .rst_n_i        (rst_n_i),
    .read_addr1_i   (instr_i[19:15]),
    .read_addr2_i   (instr_i[24:20]),
    .write_addr_i   (instr_i[11:7]),
    .write_data_i   (wb_data),
    .write_enable_i (gpr_we),
    .read_data1_o   (rs1_data),
    .read_data2_o   (rs2_data)
  );

  csr_riscv u_csr (
    .clk_i      (clk_i),
    .rst_n_i    (rst_n_i),
    .int_i      (int_i),
    .op_i       (csr_op),
    .csr_i      (csr),
    .mret_i     (int_rst),
    .addr_i     (instr_i[31:20]),
    .pc_i       (pc_q),
    .wdata_i    (rs1_data),
    .enable_i   (enpc),
    .rdata_o    (csr_rdata),
    .mtvec_o    (mtvec),
    .mepc_o     (mepc),
    .int_take_o (int_take)
  );

  // the same instruction stays presented until memory drops the stall
  a_stall_holds_pc: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    data_stall_i |=> $stable(instr_addr_o))
    else $error("pc moved during a data stall");

endmodule

// File: verification/tb_core_riscv.sv
`timescale 1ns/10ps

module tb_core_riscv
  import riscv_isa_pkg::*;
();

  localparam int END_WORD   = 36;
  localparam int INT_WORD   = 33;
  localparam int STALL_LEN  = 3;
  localparam int MAX_CYCLES = 2 * 52 + STALL_LEN + 40;

  logic        clk_i;
  logic        rst_n_i;
  logic [31:0] instr_i;
  logic [31:0] data_rdata_i;
  logic        data_stall_i;
  logic        int_i;
  logic [31:0] instr_addr_o;
  logic        data_req_o;
  logic        data_we_o;
  logic [2:0]  data_size_o;
  logic [31:0] data_addr_o;
  logic [31:0] data_wdata_o;
  logic        illegal_instr_o;

  logic [31:0] imem [256];
  logic [31:0] lfsr_state;
  int          errors;
  int          cycles;
  bit          done;

  // reference model state
  logic [31:0] m_pc;
  logic [31:0] m_regs [32];
  logic [31:0] m_mtvec;
  logic [31:0] m_mepc;
  logic [31:0] m_mcause;
  logic        m_insvc;
  int          stall_left;
  int          int_left;
  bit          int_done;

  // decoded view of the instruction at m_pc
  logic [31:0] d_instr;
  logic [6:0]  d_op;
  logic [2:0]  d_f3;
  logic [31:0] d_r1;
  logic [31:0] d_r2;
  logic [31:0] d_imm_i;
  logic [31:0] d_imm_s;
  logic        d_ill;
  logic        d_req;
  logic [31:0] d_addr;

  core_riscv UUT (.*);

  assign instr_i = imem[instr_addr_o[9:2]];

  initial begin
    clk_i = 1'b0;
    forever #10 clk_i = ~clk_i;
  end

  // ##################################################
  // program encoding
  // ##################################################

  function automatic logic [31:0] lfsr_bits(input int n);
    logic [31:0] r;
    r = '0;
    for (int i = 0; i < n; i++) begin
      lfsr_state = lfsr_state[0] ? ((lfsr_state >> 1) ^ 32'h8020_0003) : (lfsr_state >> 1);
      r = {r[30:0], lfsr_state[0]};
    end
    return r;
  endfunction

  function automatic logic [31:0] enc_i(logic [11:0] imm, logic [4:0] rs1, logic [2:0] f3,
                                       logic [4:0] rd, logic [6:0] op);
    return {imm, rs1, f3, rd, op};
  endfunction

  function automatic logic [31:0] enc_r(logic [6:0] f7, logic [4:0] rs2, logic [4:0] rs1,
                                       logic [2:0] f3, logic [4:0] rd);
    return {f7, rs2, rs1, f3, rd, 7'b0110011};
  endfunction

  function automatic logic [31:0] enc_s(logic [11:0] imm, logic [4:0] rs2, logic [4:0] rs1);
    return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], 7'b0100011};
  endfunction

  function automatic logic [31:0] enc_b(logic [12:0] imm, logic [4:0] rs2, logic [4:0] rs1,
                                       logic [2:0] f3);
    return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], 7'b1100011};
  endfunction

  function automatic logic [31:0] enc_j(logic [20:0] imm, logic [4:0] rd);
    return {imm[20], imm[10:1], imm[11], imm[19:12], rd, 7'b1101111};
  endfunction

  function automatic logic [31:0] enc_u(logic [19:0] imm, logic [4:0] rd);
    return {imm, rd, 7'b0110111};
  endfunction

  task automatic load_program();
    for (int a = 0; a < 256; a++)
      imem[a] = enc_i(a * 4 + 1, 5'd0, 3'b000, 5'd0, 7'b0010011);
    imem[0]  = enc_u(lfsr_bits(20), 5'd1);
    imem[1]  = enc_i(lfsr_bits(12), 5'd1, 3'b000, 5'd1, 7'b0010011);
    imem[2]  = enc_u(lfsr_bits(20), 5'd2);
    imem[3]  = enc_i(lfsr_bits(12), 5'd2, 3'b000, 5'd2, 7'b0010011);
    imem[4]  = enc_r(FUNCT7_BASE, 5'd2, 5'd1, 3'b000, 5'd3);
    imem[5]  = enc_r(FUNCT7_ALT, 5'd2, 5'd1, 3'b000, 5'd4);
    imem[6]  = enc_r(FUNCT7_BASE, 5'd2, 5'd1, 3'b100, 5'd5);
    imem[7]  = enc_r(FUNCT7_BASE, 5'd2, 5'd1, 3'b001, 5'd6);
    imem[8]  = enc_r(FUNCT7_ALT, 5'd2, 5'd1, 3'b101, 5'd7);
    for (int k = 0; k < 5; k++)
      imem[9 + k] = enc_s(lfsr_bits(12), 5'd3 + k, 5'd0);
    // control flow section
    imem[14] = enc_b(13'd8, 5'd1, 5'd1, 3'b000);
    imem[15] = enc_i(12'd1, 5'd0, 3'b000, 5'd8, 7'b0010011);
    imem[16] = enc_b(13'd8, 5'd1, 5'd1, 3'b001);
    imem[17] = enc_j(21'd8, 5'd9);
    imem[19] = enc_i(12'd92, 5'd0, 3'b000, 5'd10, 7'b0010011);
    imem[20] = enc_i(12'd0, 5'd10, 3'b000, 5'd11, 7'b1100111);
    imem[23] = enc_s(lfsr_bits(12), 5'd9, 5'd0);
    imem[24] = enc_s(lfsr_bits(12), 5'd11, 5'd0);
    imem[25] = enc_i(lfsr_bits(12), 5'd0, 3'b010, 5'd12, 7'b0000011);
    imem[26] = enc_s(lfsr_bits(12), 5'd12, 5'd0);
    // illegal words
    imem[27] = enc_r(7'b0000001, 5'd2, 5'd1, 3'b000, 5'd19);
    imem[28] = enc_b(13'd8, 5'd1, 5'd1, 3'b010);
    imem[29] = 32'h0000_007F;
    // interrupt section with the handler at word 48
    imem[30] = enc_i(12'd192, 5'd0, 3'b000, 5'd13, 7'b0010011);
    imem[31] = enc_i(CSR_MTVEC, 5'd13, 3'b001, 5'd14, 7'b1110011);
    imem[32] = enc_i(12'd5, 5'd0, 3'b000, 5'd15, 7'b0010011);
    imem[33] = enc_i(12'd7, 5'd0, 3'b000, 5'd16, 7'b0010011);
    imem[34] = enc_s(lfsr_bits(12), 5'd16, 5'd0);
    imem[35] = enc_s(lfsr_bits(12), 5'd14, 5'd0);
    imem[36] = enc_j(21'd0, 5'd0);
    imem[48] = enc_i(12'd3, 5'd0, 3'b000, 5'd17, 7'b0010011);
    imem[49] = enc_i(CSR_MEPC, 5'd0, 3'b010, 5'd18, 7'b1110011);
    imem[50] = enc_s(lfsr_bits(12), 5'd18, 5'd0);
    imem[51] = {MRET_FIELD, 13'd0, 7'b1110011};
  endtask

  // ##################################################
  // reference model
  // ##################################################

  task automatic decode_model();
    d_instr = imem[m_pc[9:2]];
    d_op    = d_instr[6:0];
    d_f3    = d_instr[14:12];
    d_r1    = m_regs[d_instr[19:15]];
    d_r2    = m_regs[d_instr[24:20]];
    d_imm_i = {{20{d_instr[31]}}, d_instr[31:20]};
    d_imm_s = {{20{d_instr[31]}}, d_instr[31:25], d_instr[11:7]};
    d_ill   = !(d_op inside {LOAD, MISC_MEM, OP_IMM, AUIPC, STORE, OP, LUI, BRANCH, JALR,
                             JAL, SYSTEM});
    if (d_op == OP && !(d_instr[31:25] inside {FUNCT7_BASE, FUNCT7_ALT}))
      d_ill = 1'b1;
    if (d_op == BRANCH && d_f3 inside {3'b010, 3'b011})
      d_ill = 1'b1;
    d_req  = (d_op == LOAD || d_op == STORE) && !d_ill && !(int_i && !m_insvc);
    d_addr = d_r1 + ((d_op == STORE) ? d_imm_s : d_imm_i);
  endtask

  task automatic step_model();
    logic [31:0] nxt;
    logic [31:0] wv;
    logic [31:0] old;
    logic        wr;
    logic        take;
    decode_model();
    nxt  = m_pc + 4;
    wv   = '0;
    wr   = 1'b0;
    take = int_i && !m_insvc;
    case (d_op)
      LUI:    begin wr = 1'b1; wv = {d_instr[31:12], 12'b0}; end
      OP_IMM: begin wr = 1'b1; wv = d_r1 + d_imm_i; end
      LOAD:   begin wr = 1'b1; wv = data_rdata_i; end
      OP: begin
        wr = 1'b1;
        case ({d_instr[30], d_f3})
          4'b1_000: wv = d_r1 - d_r2;
          4'b0_001: wv = d_r1 << d_r2[4:0];
          4'b0_100: wv = d_r1 ^ d_r2;
          4'b1_101: wv = $signed(d_r1) >>> d_r2[4:0];
          default:  wv = d_r1 + d_r2;
        endcase
      end
      BRANCH: begin
        if ((d_f3 == 3'b000) == (d_r1 == d_r2))
          nxt = m_pc + {{20{d_instr[31]}}, d_instr[7], d_instr[30:25], d_instr[11:8], 1'b0};
      end
      JAL: begin
        wr  = 1'b1;
        wv  = m_pc + 4;
        nxt = m_pc + {{12{d_instr[31]}}, d_instr[19:12], d_instr[20], d_instr[30:21], 1'b0};
      end
      JALR: begin
        wr  = 1'b1;
        wv  = m_pc + 4;
        nxt = (d_r1 + d_imm_i) & ~32'd1;
      end
      SYSTEM: begin
        if (d_f3 == 3'b000) begin
          nxt     = m_mepc;
          m_insvc = 1'b0;
        end else begin
          case (d_instr[31:20])
            CSR_MTVEC: old = m_mtvec;
            CSR_MEPC:  old = m_mepc;
            default:   old = m_mcause;
          endcase
          wr = 1'b1;
          wv = old;
          old = (d_f3 == 3'b001) ? d_r1 : (old | d_r1);
          case (d_instr[31:20])
            CSR_MTVEC: m_mtvec = old;
            CSR_MEPC:  m_mepc = old;
            default:   m_mcause = old;
          endcase
        end
      end
      default: ;
    endcase
    if (d_ill) begin
      wr  = 1'b0;
      nxt = m_pc + 4;
    end
    if (take) begin
      m_mepc   = m_pc;
      m_mcause = INT_CAUSE;
      m_insvc  = 1'b1;
      nxt      = m_mtvec;
    end
    if (wr && d_instr[11:7] != 5'd0)
      m_regs[d_instr[11:7]] = wv;
    m_pc = nxt;
  endtask

  // the model steps on the rising edge where the stall, load data and interrupt are driven
  always @(posedge clk_i) begin
    cycles++;
    if (!rst_n_i) begin
      m_pc    = '0;
      m_insvc = 1'b0;
      m_mtvec = '0;
      m_mepc  = '0;
      for (int i = 0; i < 32; i++)
        m_regs[i] = '0;
    end else begin
      if (!data_stall_i)
        step_model();
      if (data_stall_i) begin
        stall_left--;
        if (stall_left == 0) begin
          data_stall_i <= 1'b0;
          data_rdata_i <= lfsr_bits(32);
        end
      end else if (imem[m_pc[9:2]][6:0] == LOAD) begin
        data_stall_i <= 1'b1;
        stall_left = STALL_LEN;
      end
      if (!int_done && m_pc == INT_WORD * 4) begin
        int_i    <= 1'b1;
        int_left = 4;
        int_done = 1'b1;
      end else if (int_i) begin
        int_left--;
        if (int_left == 0)
          int_i <= 1'b0;
      end
      if (m_pc == END_WORD * 4)
        done = 1'b1;
    end
  end

  task automatic report_error(input string msg);
    errors++;
    $display("error %0t: %s", $time, msg);
  endtask

  always @(negedge clk_i) begin
    if (rst_n_i && !done) begin
      decode_model();
      a_pc: assert (instr_addr_o == m_pc)
        else report_error($sformatf("pc %h expected %h", instr_addr_o, m_pc));
      a_req: assert (data_req_o == d_req)
        else report_error($sformatf("data_req_o %b expected %b at pc %h", data_req_o, d_req,
                                    m_pc));
      a_illegal: assert (illegal_instr_o == d_ill)
        else report_error($sformatf("illegal_instr_o %b expected %b", illegal_instr_o, d_ill));
      if (d_req) begin
        a_addr: assert (data_addr_o == d_addr && data_we_o == (d_op == STORE))
          else report_error($sformatf("data_addr_o %h expected %h", data_addr_o, d_addr));
        a_size: assert (data_size_o == d_f3)
          else report_error($sformatf("data_size_o %h expected %h", data_size_o, d_f3));
        if (d_op == STORE) begin
          a_wdata: assert (data_wdata_o == d_r2)
            else report_error($sformatf("data_wdata_o %h expected %h", data_wdata_o, d_r2));
        end
      end
    end
  end

  initial begin
    errors       = 0;
    cycles       = 0;
    done         = 1'b0;
    int_done     = 1'b0;
    lfsr_state   = 32'd81603;
    rst_n_i      = 1'b0;
    data_rdata_i = '0;
    data_stall_i = 1'b0;
    int_i        = 1'b0;
    load_program();
    repeat (5) @(posedge clk_i);
    rst_n_i <= 1'b1;
    wait (done || cycles >= MAX_CYCLES);
    if (!done) begin
      errors++;
      $display("run stopped after %0d cycles without reaching the end of the program", cycles);
    end
    $display("errors: %0d, cycles: %0d", errors, cycles);
    if (errors == 0)
      $display("All tests passed");
    else
      $display("Some tests failed");
    $finish;
  end

endmodule

// File: core_riscv.f
common/riscv_isa_pkg.sv
common/riscv_ctrl_pkg.sv
source/decoder_riscv.sv
source/alu_riscv.sv
source/rf_riscv.sv
source/csr_riscv.sv
source/core_riscv.sv
verification/tb_core_riscv.sv

// File: Bender.yml
package:
  name: core_riscv

sources:
  - common/riscv_isa_pkg.sv
  - common/riscv_ctrl_pkg.sv
  - source/decoder_riscv.sv
  - source/alu_riscv.sv
  - source/rf_riscv.sv
  - source/csr_riscv.sv
  - source/core_riscv.sv
  - target: test
    files:
      - verification/tb_core_riscv.sv
